/* usbHostPkg.sv */
package usbHostPkg;

  localparam int MAX_PKT     = 8;           // EP0 and EP1 max packet size
  localparam int BUF_DEPTH   = 64;          // Descriptor store in bytes
  localparam int REGION_SIZE = BUF_DEPTH / 2;

  typedef enum logic [1:0] {
    TXN_SETUP,
    TXN_OUT,
    TXN_IN
  } txnType_t;

  typedef enum logic [1:0] {
    RSP_ACK,
    RSP_NAK,
    RSP_STALL,
    RSP_DATA                                // IN data returned
  } rspCode_t;

  typedef enum logic {
    REGION_DEVICE,                          // Bytes 0 to 31
    REGION_CONFIG                           // Bytes 32 to 63
  } descRegion_t;

  typedef logic [8*MAX_PKT-1:0] pktData_t;  // Byte 0 in bits 7:0
  typedef logic [3:0]           pktLen_t;
  typedef logic [6:0]           usbAddr_t;
  typedef logic [3:0]           usbEndp_t;

  localparam usbAddr_t   DEV_ADDR            = 7'd55;
  localparam logic [7:0] BREQ_GET_DESCRIPTOR = 8'd6;
  localparam logic [7:0] BREQ_SET_ADDRESS    = 8'd5;
  localparam logic [7:0] DESC_DEVICE         = 8'd1;
  localparam logic [7:0] DESC_CONFIG         = 8'd2;
  localparam logic [7:0] DESC_STRING         = 8'd3;
  localparam logic [7:0] REQTYPE_DEV_TO_HOST = 8'h80; // Standard, device recipient
  localparam logic [7:0] REQTYPE_HOST_TO_DEV = 8'h00;

  localparam logic [15:0] DEV_DESC_LEN = 16'd18;
  localparam logic [15:0] MAX_DESC_LEN = 16'hFFFF;    // Read until short packet

  localparam pktData_t LOOPBACK_DATA = 64'h0011_2233_4455_6677;
  localparam int       LOOPBACK_LEN  = 5;             // Low five bytes go out

  // Setup packet, bmRequestType is the first byte on the wire
  typedef struct packed {
    logic [15:0] wLength;
    logic [15:0] wIndex;
    logic [15:0] wValue;
    logic [7:0]  bRequest;
    logic [7:0]  bmRequestType;
  } setupPkt_t;

  localparam setupPkt_t SETUP_GET_DEVICE = '{wLength: DEV_DESC_LEN, wIndex: 16'h0000,
    wValue: {DESC_DEVICE, 8'h00}, bRequest: BREQ_GET_DESCRIPTOR,
    bmRequestType: REQTYPE_DEV_TO_HOST};
  localparam setupPkt_t SETUP_GET_CONFIG = '{wLength: MAX_DESC_LEN, wIndex: 16'h0000,
    wValue: {DESC_CONFIG, 8'h00}, bRequest: BREQ_GET_DESCRIPTOR,
    bmRequestType: REQTYPE_DEV_TO_HOST};
  localparam setupPkt_t SETUP_GET_STRING = '{wLength: MAX_DESC_LEN, wIndex: 16'h0000,
    wValue: {DESC_STRING, 8'h00}, bRequest: BREQ_GET_DESCRIPTOR,
    bmRequestType: REQTYPE_DEV_TO_HOST};
  localparam setupPkt_t SETUP_SET_ADDRESS = '{wLength: 16'h0000, wIndex: 16'h0000,
    wValue: {9'd0, DEV_ADDR}, bRequest: BREQ_SET_ADDRESS,
    bmRequestType: REQTYPE_HOST_TO_DEV};

endpackage

/* usbHostIf.sv */
interface usbTxnIf import usbHostPkg::*; ();
  logic      req;
  txnType_t  txnType;
  usbAddr_t  addr;
  usbEndp_t  endp;
  pktData_t  data;
  pktLen_t   nBytes;
  logic      ack;
  rspCode_t  rspCode;
  pktData_t  rspData;                       // Valid while ack is high
  pktLen_t   rspBytes;

  modport master (output req, txnType, addr, endp, data, nBytes,
                  input  ack, rspCode, rspData, rspBytes);
  modport slave  (input  req, txnType, addr, endp, data, nBytes,
                  output ack, rspCode, rspData, rspBytes);
endinterface

interface descWrIf import usbHostPkg::*; ();
  logic        wrValid;                     // One cycle per IN data packet
  logic        wrStart;                     // Restart count of region
  descRegion_t region;
  pktData_t    data;
  pktLen_t     nBytes;

  modport master (output wrValid, wrStart, region, data, nBytes);
  modport slave  (input  wrValid, wrStart, region, data, nBytes);
endinterface

/* hostEnumSequencer.sv */
module hostEnumSequencer import usbHostPkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  usbTxnIf.master  txn,
  descWrIf.master  desc,
  output usbAddr_t o_devAddr,
  output logic     o_enumDone,
  output logic     o_enumError,
  output logic     o_stallSeen,
  output logic     o_loopbackOk
);

  typedef enum logic [3:0] {
    STEP_DEV_SETUP,
    STEP_DEV_DATA,
    STEP_DEV_STATUS,
    STEP_CFG_SETUP,
    STEP_CFG_DATA,
    STEP_CFG_STATUS,
    STEP_STR_SETUP,
    STEP_STR_DATA,
    STEP_STR_STATUS,
    STEP_ADR_SETUP,
    STEP_ADR_STATUS,
    STEP_LB_OUT,
    STEP_LB_IN,
    STEP_END
  } step_t;

  typedef enum logic [1:0] {
    PH_IDLE,                                // Waiting for ack low, then issue
    PH_REQ,                                 // Req high, waiting for ack
    PH_HALT                                 // Done or error
  } phase_t;

  step_t       step;
  phase_t      phase;
  logic [15:0] rxCount;                     // Bytes in current data stage
  logic [15:0] rxTotal;
  logic [15:0] wLength;
  logic        dataLast;
  logic        rspOk;
  logic        loopMatch;
  logic        setupStep;
  logic        cfgStage;

  // Request fields follow the step, so they hold while req is high
  always_comb begin
    txn.txnType = TXN_IN;
    txn.endp    = 4'd0;
    txn.data    = '0;
    txn.nBytes  = '0;
    case (step)
      STEP_DEV_SETUP: begin
        txn.txnType = TXN_SETUP;
        txn.data    = SETUP_GET_DEVICE;
        txn.nBytes  = pktLen_t'(MAX_PKT);
      end
      STEP_CFG_SETUP: begin
        txn.txnType = TXN_SETUP;
        txn.data    = SETUP_GET_CONFIG;
        txn.nBytes  = pktLen_t'(MAX_PKT);
      end
      STEP_STR_SETUP: begin
        txn.txnType = TXN_SETUP;
        txn.data    = SETUP_GET_STRING;
        txn.nBytes  = pktLen_t'(MAX_PKT);
      end
      STEP_ADR_SETUP: begin
        txn.txnType = TXN_SETUP;
        txn.data    = SETUP_SET_ADDRESS;
        txn.nBytes  = pktLen_t'(MAX_PKT);
      end
      STEP_DEV_STATUS, STEP_CFG_STATUS, STEP_STR_STATUS: begin
        txn.txnType = TXN_OUT;              // Zero-length status
      end
      STEP_LB_OUT: begin
        txn.txnType = TXN_OUT;
        txn.endp    = 4'd1;
        txn.data    = LOOPBACK_DATA;
        txn.nBytes  = pktLen_t'(LOOPBACK_LEN);
      end
      STEP_LB_IN: begin
        txn.endp    = 4'd1;
      end
      default: begin
        txn.txnType = TXN_IN;               // Data stages and SET_ADDRESS status
      end
    endcase
  end

  assign txn.addr = o_devAddr;              // Old address until status completes

  always_comb begin
    case (step)
      STEP_DEV_DATA: wLength = SETUP_GET_DEVICE.wLength;
      STEP_CFG_DATA: wLength = SETUP_GET_CONFIG.wLength;
      default:       wLength = SETUP_GET_STRING.wLength;
    endcase
  end

  assign rxTotal   = rxCount + 16'(txn.rspBytes);
  assign dataLast  = (txn.rspBytes < pktLen_t'(MAX_PKT)) || (rxTotal >= wLength);
  assign rspOk     = (txn.txnType == TXN_IN) ? (txn.rspCode == RSP_DATA)
                                             : (txn.rspCode == RSP_ACK);
  assign loopMatch = (txn.rspBytes == pktLen_t'(LOOPBACK_LEN)) &&
                     (txn.rspData[8*LOOPBACK_LEN-1:0] == LOOPBACK_DATA[8*LOOPBACK_LEN-1:0]);
  assign setupStep = (txn.txnType == TXN_SETUP);
  assign cfgStage  = (step == STEP_CFG_SETUP) || (step == STEP_CFG_DATA);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      step         <= STEP_DEV_SETUP;
      phase        <= PH_IDLE;
      txn.req      <= 1'b0;
      rxCount      <= '0;
      o_devAddr    <= '0;
      o_enumDone   <= 1'b0;
      o_enumError  <= 1'b0;
      o_stallSeen  <= 1'b0;
      o_loopbackOk <= 1'b0;
      desc.wrValid <= 1'b0;
      desc.wrStart <= 1'b0;
    end else begin
      desc.wrValid <= 1'b0;
      desc.wrStart <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (!txn.ack) begin               // Previous handshake closed
            txn.req <= 1'b1;
            phase   <= PH_REQ;
            if (setupStep) begin
              rxCount <= '0;
            end
            if (step == STEP_DEV_SETUP || step == STEP_CFG_SETUP) begin
              desc.wrStart <= 1'b1;
              desc.region  <= cfgStage ? REGION_CONFIG : REGION_DEVICE;
            end
          end
        end
        PH_REQ: begin
          if (txn.ack) begin
            txn.req     <= 1'b0;
            phase       <= PH_IDLE;
            desc.data   <= txn.rspData;
            desc.nBytes <= txn.rspBytes;
            desc.region <= cfgStage ? REGION_CONFIG : REGION_DEVICE;
            if (txn.rspCode == RSP_NAK) begin
              phase <= PH_IDLE;             // Same transaction again
            end else if (txn.rspCode == RSP_STALL && step == STEP_STR_DATA) begin
              o_stallSeen <= 1'b1;          // Unsupported string, expected
              step        <= STEP_ADR_SETUP;
            end else if (!rspOk) begin
              o_enumError <= 1'b1;
              phase       <= PH_HALT;
            end else begin
              case (step)
                STEP_DEV_DATA, STEP_CFG_DATA, STEP_STR_DATA: begin
                  rxCount      <= rxTotal;
                  desc.wrValid <= (step != STEP_STR_DATA);
                  if (dataLast) begin
                    step <= step_t'(step + 4'd1);
                  end
                end
                STEP_STR_STATUS: step <= STEP_ADR_SETUP;
                STEP_ADR_STATUS: begin
                  o_devAddr <= DEV_ADDR;
                  step      <= STEP_LB_OUT;
                end
                STEP_LB_IN: begin
                  o_loopbackOk <= loopMatch;
                  o_enumDone   <= 1'b1;
                  step         <= STEP_END;
                  phase        <= PH_HALT;
                end
                default: step <= step_t'(step + 4'd1);
              endcase
            end
          end
        end
        default: begin
          txn.req <= 1'b0;                  // Halted
        end
      endcase
    end
  end

endmodule

/* hostTxnPort.sv */
module hostTxnPort import usbHostPkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  usbTxnIf.slave   txn,

  output logic     o_txnReq,
  output txnType_t o_txnType,
  output usbAddr_t o_txnAddr,
  output usbEndp_t o_txnEndp,
  output pktData_t o_txnData,
  output pktLen_t  o_txnBytes,
  output logic     o_txnPid,                // 0 = DATA0
  input  logic     i_txnAck,
  input  rspCode_t i_rspCode,
  input  pktData_t i_rspData,
  input  pktLen_t  i_rspBytes
);

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_BUS,                               // External req high
    PORT_DONE                               // Internal ack high
  } portState_t;

  portState_t state;
  logic [1:0] dataToggle;                   // One per endpoint, 0 and 1
  logic       epSel;
  logic       newReq;
  logic       busAck;

  assign epSel  = (o_txnEndp == 4'd1);
  assign newReq = (state == PORT_IDLE) && txn.req;
  assign busAck = (state == PORT_BUS) && i_txnAck;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= PORT_IDLE;
      o_txnReq   <= 1'b0;
      txn.ack    <= 1'b0;
      dataToggle <= 2'b00;
    end else begin
      case (state)
        PORT_IDLE: begin
          if (txn.req) begin
            o_txnReq <= 1'b1;
            state    <= PORT_BUS;
          end
        end
        PORT_BUS: begin
          if (i_txnAck) begin
            o_txnReq <= 1'b0;
            txn.ack  <= 1'b1;
            state    <= PORT_DONE;
            case (o_txnType)
              TXN_SETUP: dataToggle[epSel] <= 1'b1;
              TXN_OUT: begin
                if (i_rspCode == RSP_ACK) begin
                  dataToggle[epSel] <= ~dataToggle[epSel];
                end
              end
              default: begin
                if (i_rspCode == RSP_DATA) begin
                  dataToggle[epSel] <= ~dataToggle[epSel]; // Host ACKs the data
                end
              end
            endcase
          end
        end
        default: begin
          if (!txn.req && !i_txnAck) begin
            txn.ack <= 1'b0;
            state   <= PORT_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (newReq) begin
      o_txnType  <= txn.txnType;
      o_txnAddr  <= txn.addr;
      o_txnEndp  <= txn.endp;
      o_txnData  <= txn.data;
      o_txnBytes <= txn.nBytes;
      o_txnPid   <= (txn.txnType == TXN_SETUP) ? 1'b0 : dataToggle[txn.endp == 4'd1];
    end
    if (busAck) begin                       // First cycle ack is seen
      txn.rspCode  <= i_rspCode;
      txn.rspData  <= i_rspData;
      txn.rspBytes <= i_rspBytes;
    end
  end

endmodule

/* descriptorBuffer.sv */
module descriptorBuffer import usbHostPkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  descWrIf.slave      desc,
  input  logic [5:0]  i_bufAddr,
  output logic [7:0]  o_bufData,
  output logic [15:0] o_devDescBytes,
  output logic [15:0] o_cfgDescBytes
);

  logic [7:0]  mem [BUF_DEPTH];
  logic [15:0] baseCount;                   // Running count of selected region
  logic        cfgSel;

  assign cfgSel    = (desc.region == REGION_CONFIG);
  assign baseCount = cfgSel ? o_cfgDescBytes : o_devDescBytes;

  // Counts keep going past the stored 32 bytes
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_devDescBytes <= '0;
      o_cfgDescBytes <= '0;
    end else if (desc.wrStart) begin
      if (cfgSel) begin
        o_cfgDescBytes <= '0;
      end else begin
        o_devDescBytes <= '0;
      end
    end else if (desc.wrValid) begin
      if (cfgSel) begin
        o_cfgDescBytes <= o_cfgDescBytes + 16'(desc.nBytes);
      end else begin
        o_devDescBytes <= o_devDescBytes + 16'(desc.nBytes);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (desc.wrValid) begin
      for (int i = 0; i < MAX_PKT; i++) begin
        if ((i < int'(desc.nBytes)) && (int'(baseCount) + i < REGION_SIZE)) begin
          mem[{cfgSel, 5'(baseCount + 16'(i))}] <= desc.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_bufData <= mem[i_bufAddr];            // One cycle read latency
  end

endmodule

/* usbHostTop.sv */
module usbHostTop import usbHostPkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,

  // Device bus
  output logic        o_txnReq,
  output txnType_t    o_txnType,
  output usbAddr_t    o_txnAddr,
  output usbEndp_t    o_txnEndp,
  output pktData_t    o_txnData,
  output pktLen_t     o_txnBytes,
  output logic        o_txnPid,
  input  logic        i_txnAck,
  input  rspCode_t    i_rspCode,
  input  pktData_t    i_rspData,
  input  pktLen_t     i_rspBytes,

  // Descriptor readback
  input  logic [5:0]  i_bufAddr,
  output logic [7:0]  o_bufData,

  output usbAddr_t    o_devAddr,
  output logic [15:0] o_devDescBytes,
  output logic [15:0] o_cfgDescBytes,
  output logic        o_enumDone,
  output logic        o_enumError,
  output logic        o_stallSeen,
  output logic        o_loopbackOk
);

  usbTxnIf txnBus ();
  descWrIf descBus ();

  hostEnumSequencer u_sequencer (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .txn          (txnBus.master),
    .desc         (descBus.master),
    .o_devAddr    (o_devAddr),
    .o_enumDone   (o_enumDone),
    .o_enumError  (o_enumError),
    .o_stallSeen  (o_stallSeen),
    .o_loopbackOk (o_loopbackOk)
  );

  hostTxnPort u_port (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .txn        (txnBus.slave),
    .o_txnReq   (o_txnReq),
    .o_txnType  (o_txnType),
    .o_txnAddr  (o_txnAddr),
    .o_txnEndp  (o_txnEndp),
    .o_txnData  (o_txnData),
    .o_txnBytes (o_txnBytes),
    .o_txnPid   (o_txnPid),
    .i_txnAck   (i_txnAck),
    .i_rspCode  (i_rspCode),
    .i_rspData  (i_rspData),
    .i_rspBytes (i_rspBytes)
  );

  descriptorBuffer u_descBuf (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .desc           (descBus.slave),
    .i_bufAddr      (i_bufAddr),
    .o_bufData      (o_bufData),
    .o_devDescBytes (o_devDescBytes),
    .o_cfgDescBytes (o_cfgDescBytes)
  );

endmodule

/* usbHostTop_sva.sv */
module usbHostTop_sva import usbHostPkg::*; (
  input logic     i_clk,
  input logic     i_rst,
  input logic     o_txnReq,
  input txnType_t o_txnType,
  input usbAddr_t o_txnAddr,
  input usbEndp_t o_txnEndp,
  input pktData_t o_txnData,
  input pktLen_t  o_txnBytes,
  input logic     o_txnPid,
  input logic     i_txnAck,
  input logic     o_enumError
);
  timeunit 1ns;
  timeprecision 1ps;

  reqRiseAckLow: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_txnReq) |-> !i_txnAck)
    else $error("Host request raised while device ack still high");

  // Fields held from req rise until req drops
  reqFieldsStable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_txnReq && $past(o_txnReq) |->
      $stable({o_txnType, o_txnAddr, o_txnEndp, o_txnData, o_txnBytes, o_txnPid}))
    else $error("Request fields changed while request high");

  ackDropAfterReq: assert property (@(posedge i_clk) disable iff (i_rst)
    $fell(i_txnAck) |-> !$past(o_txnReq))
    else $error("Device ack dropped while host request high");

  noEnumError: assert property (@(posedge i_clk) disable iff (i_rst)
    !o_enumError)
    else $error("Enumeration error flag raised");

endmodule

bind usbHostTop usbHostTop_sva sva (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .o_txnReq    (o_txnReq),
  .o_txnType   (o_txnType),
  .o_txnAddr   (o_txnAddr),
  .o_txnEndp   (o_txnEndp),
  .o_txnData   (o_txnData),
  .o_txnBytes  (o_txnBytes),
  .o_txnPid    (o_txnPid),
  .i_txnAck    (i_txnAck),
  .o_enumError (o_enumError)
);

/* tb_usbHostTop.sv */
module tb_usbHostTop import usbHostPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 500;          // Cycles allowed per wait loop

  logic        i_clk = 1'b0;
  logic        i_rst;
  logic        o_txnReq;
  txnType_t    o_txnType;
  usbAddr_t    o_txnAddr;
  usbEndp_t    o_txnEndp;
  pktData_t    o_txnData;
  pktLen_t     o_txnBytes;
  logic        o_txnPid;
  logic        i_txnAck;
  rspCode_t    i_rspCode;
  pktData_t    i_rspData;
  pktLen_t     i_rspBytes;
  logic [5:0]  i_bufAddr;
  logic [7:0]  o_bufData;
  usbAddr_t    o_devAddr;
  logic [15:0] o_devDescBytes;
  logic [15:0] o_cfgDescBytes;
  logic        o_enumDone;
  logic        o_enumError;
  logic        o_stallSeen;
  logic        o_loopbackOk;

  int          seed = 32'h842f_4de2;
  logic [1:0]  toggle;                      // Expected host toggle, EP0 and EP1
  usbAddr_t    expAddr;                     // Address the host should use now
  logic [7:0]  descBytes [$];               // Descriptor the device model returns

  usbHostTop dut (.*);

  always #5 i_clk = ~i_clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic checkTxnType(input string name, input txnType_t exp, input txnType_t act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s type expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic checkAddr(input string name, input usbAddr_t exp, input usbAddr_t act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s address expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic checkEndp(input string name, input usbEndp_t exp, input usbEndp_t act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s endpoint expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic checkData(input string name, input pktData_t exp, input pktData_t act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s data expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkLen(input string name, input pktLen_t exp, input pktLen_t act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s length expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkCount(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      abortRun($sformatf("Error: %s count expected %0d actual %0d", name, exp, act));
    end
  endtask

  // Bytes beyond the packet length carry no meaning
  function automatic pktData_t byteMask(input pktLen_t len);
    pktData_t mask;
    mask = '0;
    for (int k = 0; k < MAX_PKT; k++) begin
      if (k < int'(len)) begin
        mask[8*k +: 8] = 8'hFF;
      end
    end
    return mask;
  endfunction

  // USB wire order, bmRequestType is byte 0
  function automatic pktData_t makeSetup(input logic [7:0] reqType, input logic [7:0] request,
                                         input logic [15:0] value, input logic [15:0] length);
    return {length, 16'h0000, value, request, reqType};
  endfunction

  task automatic waitReqLevel(input string name, input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge i_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abortRun($sformatf("%s: host request did not go to %0b in time", name, level));
      end
    end while (o_txnReq !== level);
  endtask

  // Device model for one transaction
  task automatic serveTxn(input string name, input txnType_t expType, input usbEndp_t expEndp,
                          input pktData_t expData, input pktLen_t expLen,
                          input rspCode_t rsp, input pktData_t rspData, input pktLen_t rspLen);
    logic ep;
    int   ackDelay;
    ep       = (expEndp == 4'd1);
    ackDelay = $unsigned($random(seed)) % 3;
    waitReqLevel(name, 1'b1);
    checkTxnType(name, expType, o_txnType);
    checkAddr(name, expAddr, o_txnAddr);
    checkEndp(name, expEndp, o_txnEndp);
    if (expType != TXN_IN) begin
      checkBit({name, " pid"}, (expType == TXN_SETUP) ? 1'b0 : toggle[ep], o_txnPid);
      checkLen(name, expLen, o_txnBytes);
      checkData(name, expData & byteMask(expLen), o_txnData & byteMask(expLen));
    end
    repeat (ackDelay) @(posedge i_clk);     // Device back-pressure
    i_txnAck   <= 1'b1;
    i_rspCode  <= rsp;
    i_rspData  <= rspData;
    i_rspBytes <= rspLen;
    waitReqLevel(name, 1'b0);
    i_txnAck   <= 1'b0;
    if (expType == TXN_SETUP) begin
      toggle[ep] = 1'b1;
    end else if (expType == TXN_OUT && rsp == RSP_ACK) begin
      toggle[ep] = ~toggle[ep];
    end else if (expType == TXN_IN && rsp == RSP_DATA) begin
      toggle[ep] = ~toggle[ep];               // Host ACKs the data
    end
  endtask

  // Each NAK must bring back the identical request
  task automatic serveAfterNaks(input string name, input txnType_t expType,
                                input usbEndp_t expEndp, input pktData_t expData,
                                input pktLen_t expLen, input rspCode_t rsp,
                                input pktData_t rspData, input pktLen_t rspLen);
    int naks;
    naks = $unsigned($random(seed)) % 4;
    repeat (naks) begin
      serveTxn({name, " nak"}, expType, expEndp, expData, expLen, RSP_NAK, '0, '0);
    end
    serveTxn(name, expType, expEndp, expData, expLen, rsp, rspData, rspLen);
  endtask

  task automatic fillDescriptor(input int len, input logic [7:0] descType);
    descBytes.delete();
    for (int i = 0; i < len; i++) begin
      descBytes.push_back(8'($random(seed)));
    end
    descBytes[0] = (descType == DESC_CONFIG) ? 8'd9 : 8'(len);
    descBytes[1] = descType;
    if (descType == DESC_CONFIG) begin
      descBytes[2] = 8'(len);               // wTotalLength
      descBytes[3] = 8'd0;
    end
  endtask

  task automatic controlRead(input string name, input pktData_t setup);
    pktData_t pkt;
    int       off;
    int       n;
    serveTxn({name, " setup"}, TXN_SETUP, 4'd0, setup, pktLen_t'(MAX_PKT), RSP_ACK, '0, '0);
    off = 0;
    while (off < descBytes.size()) begin
      n   = (descBytes.size() - off < MAX_PKT) ? descBytes.size() - off : MAX_PKT;
      pkt = '0;
      for (int k = 0; k < n; k++) begin
        pkt[8*k +: 8] = descBytes[off + k];
      end
      serveAfterNaks({name, " data"}, TXN_IN, 4'd0, '0, '0, RSP_DATA, pkt, pktLen_t'(n));
      off += n;
    end
    // Short last packet, so an OUT must follow and not another IN
    serveAfterNaks({name, " status"}, TXN_OUT, 4'd0, '0, '0, RSP_ACK, '0, '0);
    @(posedge i_clk);
  endtask

  task automatic readByte(input int addr, output logic [7:0] value);
    @(posedge i_clk);
    i_bufAddr <= 6'(addr);
    repeat (2) @(posedge i_clk);            // Registered read
    value = o_bufData;
  endtask

  task automatic checkStored(input string name, input int base, input logic [15:0] count);
    logic [7:0] value;
    checkCount(name, 16'(descBytes.size()), count);
    for (int i = 0; i < descBytes.size(); i++) begin
      readByte(base + i, value);
      checkByte($sformatf("%s byte %0d", name, i), descBytes[i], value);
    end
  endtask

  task automatic testDeviceDescriptor();
    fillDescriptor(18, DESC_DEVICE);
    controlRead("device descriptor",
                makeSetup(8'h80, BREQ_GET_DESCRIPTOR, {DESC_DEVICE, 8'h00}, DEV_DESC_LEN));
    checkStored("device descriptor", 0, o_devDescBytes);
  endtask

  task automatic testConfigDescriptor();
    fillDescriptor(20, DESC_CONFIG);
    controlRead("config descriptor",
                makeSetup(8'h80, BREQ_GET_DESCRIPTOR, {DESC_CONFIG, 8'h00}, 16'hFFFF));
    checkStored("config descriptor", 32, o_cfgDescBytes);
  endtask

  task automatic testStringDescriptor();
    serveTxn("string setup", TXN_SETUP, 4'd0,
             makeSetup(8'h80, BREQ_GET_DESCRIPTOR, {DESC_STRING, 8'h00}, 16'hFFFF),
             pktLen_t'(MAX_PKT), RSP_ACK, '0, '0);
    serveAfterNaks("string data", TXN_IN, 4'd0, '0, '0, RSP_STALL, '0, '0);
    @(posedge i_clk);
    checkBit("string stall", 1'b1, o_stallSeen);
    checkBit("string error", 1'b0, o_enumError);
  endtask

  task automatic testSetAddress();
    serveTxn("set address setup", TXN_SETUP, 4'd0,
             makeSetup(8'h00, BREQ_SET_ADDRESS, 16'(DEV_ADDR), 16'h0000),
             pktLen_t'(MAX_PKT), RSP_ACK, '0, '0);
    serveAfterNaks("set address status", TXN_IN, 4'd0, '0, '0, RSP_DATA, '0, '0);
    @(posedge i_clk);
    checkAddr("set address", DEV_ADDR, o_devAddr);
    expAddr = DEV_ADDR;                     // From here on every transaction
  endtask

  task automatic testLoopback(input logic corrupt);
    pktData_t echo;
    echo = LOOPBACK_DATA & byteMask(pktLen_t'(LOOPBACK_LEN));
    serveAfterNaks("loopback out", TXN_OUT, 4'd1, LOOPBACK_DATA, pktLen_t'(LOOPBACK_LEN),
                   RSP_ACK, '0, '0);
    if (corrupt) begin
      echo[15:8] = ~echo[15:8];
    end
    serveAfterNaks("loopback in", TXN_IN, 4'd1, '0, '0, RSP_DATA, echo,
                   pktLen_t'(LOOPBACK_LEN));
    @(posedge i_clk);
    checkBit("loopback match", !corrupt, o_loopbackOk);
    checkBit("loopback done", 1'b1, o_enumDone);
  endtask

  task automatic resetDut();
    @(posedge i_clk);
    i_rst <= 1'b1;
    repeat (16) @(posedge i_clk);
    i_rst   <= 1'b0;
    toggle  = 2'b00;
    expAddr = '0;
    checkBit("reset request", 1'b0, o_txnReq);
    checkBit("reset done", 1'b0, o_enumDone);
    checkBit("reset stall", 1'b0, o_stallSeen);
    checkBit("reset loopback", 1'b0, o_loopbackOk);
    checkAddr("reset address", '0, o_devAddr);
  endtask

  task automatic runEnumeration(input logic corrupt);
    resetDut();
    testDeviceDescriptor();
    testConfigDescriptor();
    testStringDescriptor();
    testSetAddress();
    testLoopback(corrupt);
  endtask

  initial begin
    i_rst      <= 1'b1;
    i_txnAck   <= 1'b0;
    i_rspCode  <= RSP_ACK;
    i_rspData  <= '0;
    i_rspBytes <= '0;
    i_bufAddr  <= '0;
    runEnumeration(1'b0);
    runEnumeration(1'b1);                   // Echo with one byte flipped
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* build.f */
usbHostPkg.sv
usbHostIf.sv
hostEnumSequencer.sv
hostTxnPort.sv
descriptorBuffer.sv
usbHostTop.sv
usbHostTop_sva.sv
tb_usbHostTop.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_usbHostTop \
  -f build.f -o tbSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/tbSim 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
